//--- Makefile
SRCS := $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_floo_coll_router: files.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_floo_coll_router \
		-f files.f -o Vtb_floo_coll_router

run: obj_dir/Vtb_floo_coll_router
	./obj_dir/Vtb_floo_coll_router > sim.log 2>&1; cat sim.log
	@! grep -q "RESULT: FAIL" sim.log
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
hdl/floo_coll_pkg.sv
hdl/floo_route_xymask.sv
hdl/floo_route_xy.sv
hdl/floo_reduce_collect.sv
hdl/floo_coll_ctrl.sv
hdl/floo_coll_router.sv
tests/floo_coll_router_chk.sv
tests/tb_floo_coll_router.sv

//--- hdl/floo_coll_ctrl.sv
`timescale 1ns/1ps

module floo_coll_ctrl #(
  parameter int unsigned DataWidth = 16
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Incoming header strobe
  input  logic                                   hdr_valid_i,
  input  floo_coll_pkg::hdr_t                    hdr_i,
  // Registered header for the routing units
  output floo_coll_pkg::hdr_t                    hdr_o,
  // Routing results computed from hdr_o
  input  logic [floo_coll_pkg::NumRoutes-1:0]    fwd_mask_i,
  input  logic [floo_coll_pkg::NumRoutes-1:0]    bwd_mask_i,
  input  logic [floo_coll_pkg::NumRoutes-1:0]    xy_route_i,
  // Collector interface
  output logic                                   load_o,
  output logic [floo_coll_pkg::NumRoutes-1:0]    expected_o,
  input  logic                                   done_i,
  input  logic [DataWidth-1:0]                   sum_i,
  // Results
  output logic                                   mcast_valid_o,
  output logic [floo_coll_pkg::NumRoutes-1:0]    mcast_route_o,
  output logic                                   red_valid_o,
  output logic [floo_coll_pkg::NumRoutes-1:0]    red_route_o,
  output logic [DataWidth-1:0]                   red_data_o,
  output logic                                   busy_o
);

  import floo_coll_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    Mcast,
    Collect
  } state_e;

  state_e               state_q;
  state_e               state_d;
  hdr_t                 hdr_q;
  logic                 accept;
  logic                 finish;
  logic                 load_q;
  logic                 red_valid_q;
  logic [NumRoutes-1:0] red_route_q;
  logic [DataWidth-1:0] red_data_q;

  // Mcast behaves like idle for a new header
  assign accept = hdr_valid_i && (state_q != Collect);
  assign finish = (state_q == Collect) && done_i;

  // ------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle, Mcast: begin
        if (accept) begin
          state_d = hdr_i.is_reduction ? Collect : Mcast;
        end else begin
          state_d = Idle;
        end
      end
      // Headers are ignored until the reduction completes
      Collect: begin
        if (done_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= Idle;
      load_q      <= 1'b0;
      red_valid_q <= 1'b0;
      red_route_q <= '0;
      red_data_q  <= '0;
    end else begin
      state_q     <= state_d;
      // Collector loads in the first cycle of a reduction
      load_q      <= accept && hdr_i.is_reduction;
      red_valid_q <= finish;
      if (finish) begin
        red_route_q <= xy_route_i;
        red_data_q  <= sum_i;
      end
    end
  end

  // Header register, only written on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hdr_q <= hdr_i;
    end
  end

  assign hdr_o = hdr_q;

  // Multicast mask follows the header registered one cycle earlier
  assign mcast_valid_o = (state_q == Mcast);
  assign mcast_route_o = mcast_valid_o ? fwd_mask_i : '0;

  assign load_o     = load_q;
  assign expected_o = load_q ? bwd_mask_i : '0;

  assign red_valid_o = red_valid_q;
  assign red_route_o = red_route_q;
  assign red_data_o  = red_data_q;
  assign busy_o      = (state_q == Collect);

endmodule

//--- hdl/floo_coll_pkg.sv
package floo_coll_pkg;

  // ------------------------------------------------------------
  // Mesh geometry
  // ------------------------------------------------------------

  // Bits per coordinate axis giving an 8 by 8 mesh
  localparam int unsigned CoordWidth = 3;

  // Router ports including the local eject port
  localparam int unsigned NumRoutes = 5;

  // Payload width carried next to the header in a flit
  localparam int unsigned PayloadWidth = 16;

  // Direction indices into every route vector
  localparam int unsigned North = 0;
  localparam int unsigned East  = 1;
  localparam int unsigned South = 2;
  localparam int unsigned West  = 3;
  localparam int unsigned Eject = 4;

  // ------------------------------------------------------------
  // Header and flit types
  // ------------------------------------------------------------

  // Router coordinate, also reused for the collective mask
  // where a set bit marks a don't care coordinate bit
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_id_t;

  typedef struct packed {
    xy_id_t src_id;
    xy_id_t dst_id;
    xy_id_t collective_mask;
    // Set for a reduction, clear for a multicast
    logic   is_reduction;
  } hdr_t;

  typedef struct packed {
    hdr_t                    hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

endpackage

//--- hdl/floo_coll_router.sv
`timescale 1ns/1ps

module floo_coll_router #(
  parameter int unsigned DataWidth = 16
) (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  // Coordinate of this router, held stable
  input  floo_coll_pkg::xy_id_t                              xy_id_i,
  // Header strobe
  input  logic                                               hdr_valid_i,
  input  floo_coll_pkg::hdr_t                                hdr_i,
  // Partial value arrivals per direction
  input  logic [floo_coll_pkg::NumRoutes-1:0]                in_valid_i,
  input  logic [floo_coll_pkg::NumRoutes-1:0][DataWidth-1:0] in_data_i,
  // Multicast result
  output logic                                               mcast_valid_o,
  output logic [floo_coll_pkg::NumRoutes-1:0]                mcast_route_o,
  // Reduction result
  output logic                                               red_valid_o,
  output logic [floo_coll_pkg::NumRoutes-1:0]                red_route_o,
  output logic [DataWidth-1:0]                               red_data_o,
  output logic                                               busy_o,
  output logic                                               unexpected_o
);

  import floo_coll_pkg::*;

  hdr_t                 hdr_q;
  flit_t                chan;
  logic [NumRoutes-1:0] fwd_mask;
  logic [NumRoutes-1:0] bwd_mask;
  logic [NumRoutes-1:0] xy_route;
  logic                 load;
  logic [NumRoutes-1:0] expected_mask;
  logic                 done;
  logic [DataWidth-1:0] sum;

  // Mask units only look at the header part of the flit
  assign chan.hdr     = hdr_q;
  assign chan.payload = '0;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  floo_coll_ctrl #(
    .DataWidth (DataWidth)
  ) i_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .hdr_valid_i   (hdr_valid_i),
    .hdr_i         (hdr_i),
    .hdr_o         (hdr_q),
    .fwd_mask_i    (fwd_mask),
    .bwd_mask_i    (bwd_mask),
    .xy_route_i    (xy_route),
    .load_o        (load),
    .expected_o    (expected_mask),
    .done_i        (done),
    .sum_i         (sum),
    .mcast_valid_o (mcast_valid_o),
    .mcast_route_o (mcast_route_o),
    .red_valid_o   (red_valid_o),
    .red_route_o   (red_route_o),
    .red_data_o    (red_data_o),
    .busy_o        (busy_o)
  );

  // ------------------------------------------------------------
  // Routing units
  // ------------------------------------------------------------

  // Output directions of a multicast
  floo_route_xymask #(
    .NumRoutes (NumRoutes),
    .FwdMode   (1'b1),
    .flit_t    (flit_t),
    .id_t      (xy_id_t)
  ) i_fwd_mask (
    .channel_i   (chan),
    .xy_id_i     (xy_id_i),
    .route_sel_o (fwd_mask)
  );

  // Expected input directions of a reduction
  floo_route_xymask #(
    .NumRoutes (NumRoutes),
    .FwdMode   (1'b0),
    .flit_t    (flit_t),
    .id_t      (xy_id_t)
  ) i_bwd_mask (
    .channel_i   (chan),
    .xy_id_i     (xy_id_i),
    .route_sel_o (bwd_mask)
  );

  // Single hop toward the reduction destination
  floo_route_xy i_xy (
    .dst_i   (hdr_q.dst_id),
    .xy_id_i (xy_id_i),
    .route_o (xy_route)
  );

  floo_reduce_collect #(
    .DataWidth (DataWidth)
  ) i_collect (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .load_i       (load),
    .expected_i   (expected_mask),
    .in_valid_i   (in_valid_i),
    .in_data_i    (in_data_i),
    .done_o       (done),
    .sum_o        (sum),
    .pending_o    (),
    .unexpected_o (unexpected_o)
  );

endmodule

//--- hdl/floo_reduce_collect.sv
`timescale 1ns/1ps

module floo_reduce_collect #(
  parameter int unsigned DataWidth = 16
) (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  // Start of a reduction with its expected input set
  input  logic                                               load_i,
  input  logic [floo_coll_pkg::NumRoutes-1:0]                expected_i,
  // Partial value arrivals
  input  logic [floo_coll_pkg::NumRoutes-1:0]                in_valid_i,
  input  logic [floo_coll_pkg::NumRoutes-1:0][DataWidth-1:0] in_data_i,
  // Completion strobe and final sum in the same cycle
  output logic                                               done_o,
  output logic [DataWidth-1:0]                               sum_o,
  output logic [floo_coll_pkg::NumRoutes-1:0]                pending_o,
  output logic                                               unexpected_o
);

  import floo_coll_pkg::*;

  // Outstanding inputs and running sum
  logic [NumRoutes-1:0] pending_q;
  logic [NumRoutes-1:0] pending_d;
  logic [DataWidth-1:0] sum_q;
  logic [DataWidth-1:0] sum_d;
  // Pending set seen in this cycle
  logic [NumRoutes-1:0] base;
  logic [NumRoutes-1:0] hit;
  logic                 armed;
  logic                 unexpected_q;

  // A load replaces the pending set so arrivals in the load cycle already count
  assign base      = load_i ? expected_i : pending_q;
  assign hit       = in_valid_i & base;
  assign pending_d = base & ~in_valid_i;

  // A reduction is in progress while loading or with inputs outstanding
  assign armed = load_i | (|pending_q);

  // Fires once when the last outstanding input is consumed
  assign done_o = armed & ~(|pending_d);

  // ------------------------------------------------------------
  // Accumulation
  // ------------------------------------------------------------

  always_comb begin
    sum_d = load_i ? '0 : sum_q;
    // Unsigned add wrapping modulo 2^DataWidth
    for (int unsigned i = 0; i < NumRoutes; i++) begin
      if (hit[i]) begin
        sum_d = sum_d + in_data_i[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q    <= '0;
      unexpected_q <= 1'b0;
    end else begin
      pending_q    <= pending_d;
      // A strobe on a direction not pending drops its data
      unexpected_q <= |(in_valid_i & ~base);
    end
  end

  // Running sum register
  always_ff @(posedge clk_i) begin
    sum_q <= sum_d;
  end

  assign sum_o        = sum_d;
  assign pending_o    = pending_q;
  assign unexpected_o = unexpected_q;

endmodule

//--- hdl/floo_route_xy.sv
`timescale 1ns/1ps

module floo_route_xy (
  input  floo_coll_pkg::xy_id_t                   dst_i,
  input  floo_coll_pkg::xy_id_t                   xy_id_i,
  output logic [floo_coll_pkg::NumRoutes-1:0]     route_o
);

  import floo_coll_pkg::*;

  // ------------------------------------------------------------
  // Dimension ordered selection
  // ------------------------------------------------------------

  always_comb begin
    route_o = '0;
    // X is resolved before Y is considered
    if (dst_i.x > xy_id_i.x) begin
      route_o[East] = 1'b1;
    end else if (dst_i.x < xy_id_i.x) begin
      route_o[West] = 1'b1;
    end else if (dst_i.y > xy_id_i.y) begin
      route_o[North] = 1'b1;
    end else if (dst_i.y < xy_id_i.y) begin
      route_o[South] = 1'b1;
    end else begin
      // Arrived at the destination router
      route_o[Eject] = 1'b1;
    end
  end

endmodule

//--- hdl/floo_route_xymask.sv
`timescale 1ns/1ps

module floo_route_xymask #(
  // Number of router ports covered by the mask
  parameter int unsigned NumRoutes = floo_coll_pkg::NumRoutes,
  // 1 selects output directions of a multicast
  // 0 selects expected input directions of a reduction
  parameter bit          FwdMode   = 1'b1,
  // Flit type, only its header is read
  parameter type         flit_t    = logic,
  // Coordinate type with x and y fields
  parameter type         id_t      = logic
) (
  input  flit_t                channel_i,
  input  id_t                  xy_id_i,
  output logic [NumRoutes-1:0] route_sel_o
);

  import floo_coll_pkg::*;

  // Header fields of the current collective
  id_t dst_id;
  id_t src_id;
  id_t mask;

  assign dst_id = channel_i.hdr.dst_id;
  assign src_id = channel_i.hdr.src_id;
  assign mask   = channel_i.hdr.collective_mask;

  if (FwdMode) begin : gen_fwd_mask

    // ------------------------------------------------------------
    // Multicast forward path
    // ------------------------------------------------------------

    // Extent of the destination set along each axis
    id_t  dst_max;
    id_t  dst_min;
    // Router column or row holds multicast receivers
    logic x_hit;
    logic y_hit;

    assign dst_max = dst_id | mask;
    assign dst_min = dst_id & ~mask;

    // Every unmasked bit has to agree with the destination
    assign x_hit = &(mask.x | ~(xy_id_i.x ^ dst_id.x));
    assign y_hit = &(mask.y | ~(xy_id_i.y ^ dst_id.y));

    always_comb begin
      route_sel_o = '0;

      // Local endpoint is one of the receivers
      if (x_hit && y_hit) begin
        route_sel_o[Eject] = 1'b1;
      end

      // Spread along the source row first
      // East while receivers remain beyond this column
      if (xy_id_i.y == src_id.y) begin
        if ((xy_id_i.x >= src_id.x) && (xy_id_i.x < dst_max.x)) begin
          route_sel_o[East] = 1'b1;
        end
        if ((xy_id_i.x <= src_id.x) && (xy_id_i.x > dst_min.x)) begin
          route_sel_o[West] = 1'b1;
        end
      end

      // Then fan out vertically in every receiving column
      if (x_hit) begin
        if ((xy_id_i.y >= src_id.y) && (xy_id_i.y < dst_max.y)) begin
          route_sel_o[North] = 1'b1;
        end
        if ((xy_id_i.y <= src_id.y) && (xy_id_i.y > dst_min.y)) begin
          route_sel_o[South] = 1'b1;
        end
      end
    end

  end else begin : gen_bwd_mask

    // ------------------------------------------------------------
    // Reduction backward path
    // ------------------------------------------------------------

    // Extent of the source set along each axis
    id_t  src_max;
    id_t  src_min;
    // Router column or row holds contributing sources
    logic x_hit;
    logic y_hit;

    assign src_max = src_id | mask;
    assign src_min = src_id & ~mask;

    assign x_hit = &(mask.x | ~(xy_id_i.x ^ src_id.x));
    assign y_hit = &(mask.y | ~(xy_id_i.y ^ src_id.y));

    always_comb begin
      route_sel_o = '0;

      // Local endpoint contributes one partial value
      if (x_hit && y_hit) begin
        route_sel_o[Eject] = 1'b1;
      end

      // Vertical merging only happens in the destination column
      // Partials from the north come from rows above up to the source extent
      if (xy_id_i.x == dst_id.x) begin
        if ((xy_id_i.y >= dst_id.y) && (xy_id_i.y < src_max.y)) begin
          route_sel_o[North] = 1'b1;
        end
        if ((xy_id_i.y <= dst_id.y) && (xy_id_i.y > src_min.y)) begin
          route_sel_o[South] = 1'b1;
        end
      end

      // Rows with sources first merge horizontally toward the destination column
      if (y_hit) begin
        if ((xy_id_i.x >= dst_id.x) && (xy_id_i.x < src_max.x)) begin
          route_sel_o[East] = 1'b1;
        end
        if ((xy_id_i.x <= dst_id.x) && (xy_id_i.x > src_min.x)) begin
          route_sel_o[West] = 1'b1;
        end
      end
    end

  end

endmodule

//--- tests/coll_cases.txt
// Fields per line are mode, router x y, source x y, destination x y, mask x y, expected mask
// Mode 0 is a multicast and mode 1 a reduction, mask bit 0 is North then East South West Eject
0_3_4_3_4_3_4_0_0_10
0_0_0_0_0_7_7_7_7_13
0_4_4_2_4_0_0_7_7_17
0_1_4_2_4_0_0_7_7_1d
0_2_4_2_4_0_0_7_7_1f
0_5_6_2_4_0_0_7_7_11
0_5_7_2_4_0_0_7_7_10
0_1_1_1_1_4_2_1_1_02
0_4_1_1_1_4_2_1_1_03
0_5_1_1_1_4_2_1_1_01
0_5_3_1_1_4_2_1_1_10
0_4_2_1_1_4_2_1_1_11
0_6_2_1_1_4_2_1_1_00
0_3_5_6_5_1_1_0_0_08
0_1_5_6_5_1_1_0_0_04
0_1_3_6_5_1_1_0_0_04
0_1_1_6_5_1_1_0_0_10
1_7_0_0_0_0_0_0_0_00
1_0_0_0_0_0_0_7_7_13
1_3_0_0_0_0_0_7_7_12
1_3_5_0_0_0_0_7_7_12
1_0_5_0_0_0_0_7_7_13
1_7_7_0_0_0_0_7_7_10
1_4_4_0_0_4_4_7_7_1f
1_6_5_2_2_6_5_1_0_04
1_6_2_2_2_6_5_1_0_08
1_3_2_2_2_6_5_1_0_18
1_2_2_2_2_6_5_1_0_10
1_6_3_2_2_6_5_1_0_04
1_4_6_2_2_6_5_1_0_00

//--- tests/floo_coll_router_chk.sv
`timescale 1ns/1ps

module floo_coll_router_chk (
  input logic                                clk_i,
  input logic                                rst_i,
  input logic                                mcast_valid_i,
  input logic                                red_valid_i,
  input logic [floo_coll_pkg::NumRoutes-1:0] red_route_i,
  input logic                                busy_i
);

  // Reduction result leaves through exactly one port
  red_route_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    red_valid_i |-> $onehot(red_route_i))
    else $error("red_route_o is not one-hot while red_valid_o is high");

  // The two result strobes never overlap
  strobes_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mcast_valid_i && red_valid_i))
    else $error("mcast_valid_o and red_valid_o are high together");

  // Busy drops in the very cycle of the reduction result
  busy_falls_on_result: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(busy_i) |-> red_valid_i)
    else $error("busy_o fell without red_valid_o");

  result_ends_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    red_valid_i |-> $fell(busy_i))
    else $error("red_valid_o without busy_o falling");

endmodule

bind floo_coll_router floo_coll_router_chk i_chk (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .mcast_valid_i (mcast_valid_o),
  .red_valid_i   (red_valid_o),
  .red_route_i   (red_route_o),
  .busy_i        (busy_o)
);

//--- tests/tb_floo_coll_router.sv
`timescale 1ns/1ps

module tb_floo_coll_router;

  import floo_coll_pkg::*;

  localparam int unsigned DataWidth = 16;
  localparam int unsigned MaxCases  = 64;
  localparam int unsigned Timeout   = 40;

  logic                                clk_i;
  logic                                rst_i;
  xy_id_t                              xy_id_i;
  logic                                hdr_valid_i;
  hdr_t                                hdr_i;
  logic [NumRoutes-1:0]                in_valid_i;
  logic [NumRoutes-1:0][DataWidth-1:0] in_data_i;
  logic                                mcast_valid_o;
  logic [NumRoutes-1:0]                mcast_route_o;
  logic                                red_valid_o;
  logic [NumRoutes-1:0]                red_route_o;
  logic [DataWidth-1:0]                red_data_o;
  logic                                busy_o;
  logic                                unexpected_o;

  // One case per word with mode nibble f marking an unused slot
  logic [43:0]                         cases_mem [MaxCases];
  int unsigned                         num_cases;

  floo_coll_router #(
    .DataWidth (DataWidth)
  ) floo_coll_router_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      abort_run("output differs from expected value");
    end
  endtask

  // Single XY hop resolving x before y and ejecting on arrival
  function automatic logic [NumRoutes-1:0] xy_hop(input logic [2:0] rx, input logic [2:0] ry,
                                                  input logic [2:0] dx, input logic [2:0] dy);
    logic [NumRoutes-1:0] hop;
    hop = '0;
    if (dx != rx) hop[(dx > rx) ? East : West] = 1'b1;
    else if (dy != ry) hop[(dy > ry) ? North : South] = 1'b1;
    else hop[Eject] = 1'b1;
    return hop;
  endfunction

  // ------------------------------------------------------------
  // Case drivers
  // ------------------------------------------------------------

  // Raises the header strobe on a falling edge
  task automatic load_header(input logic [43:0] c);
    xy_id_i.x                = c[38:36];
    xy_id_i.y                = c[34:32];
    hdr_i.src_id.x           = c[30:28];
    hdr_i.src_id.y           = c[26:24];
    hdr_i.dst_id.x           = c[22:20];
    hdr_i.dst_id.y           = c[18:16];
    hdr_i.collective_mask.x  = c[14:12];
    hdr_i.collective_mask.y  = c[10:8];
    hdr_i.is_reduction       = c[40];
    hdr_valid_i              = 1'b1;
  endtask

  task automatic run_mcast(input logic [43:0] c);
    load_header(c);
    @(negedge clk_i);
    hdr_valid_i = 1'b0;
    // Fixed latency of one cycle even for an empty mask
    check_value("mcast_valid_o", 32'(mcast_valid_o), 1);
    check_value("mcast_route_o", 32'(mcast_route_o), 32'(c[4:0]));
    check_value("red_valid_o", 32'(red_valid_o), 0);
    check_value("busy_o", 32'(busy_o), 0);
    @(negedge clk_i);
    check_value("mcast_valid_o", 32'(mcast_valid_o), 0);
  endtask

  task automatic run_reduction(input logic [43:0] c);
    logic [NumRoutes-1:0] exp_mask;
    logic [DataWidth-1:0] exp_sum;
    logic [DataWidth-1:0] data;
    int unsigned          order [$];
    int unsigned          pick;
    int unsigned          stray;
    int unsigned          wait_cycles;
    exp_mask = c[4:0];
    exp_sum  = '0;
    stray    = NumRoutes;
    for (int unsigned i = 0; i < NumRoutes; i++) begin
      if (exp_mask[i]) order.push_back(i);
      else if (stray == NumRoutes) stray = i;
    end
    load_header(c);
    @(negedge clk_i);
    hdr_valid_i = 1'b0;
    check_value("busy_o", 32'(busy_o), 1);
    if (exp_mask == '0) begin
      // Nothing to collect so the result follows in cycle 2
      @(negedge clk_i);
    end else begin
      // Busy header with another target must leave no trace
      hdr_i.dst_id       = ~hdr_i.dst_id;
      hdr_i.is_reduction = 1'b0;
      hdr_valid_i        = 1'b1;
      // Stray arrival on a direction outside the pending set
      if (stray < NumRoutes) begin
        in_valid_i[stray] = 1'b1;
        in_data_i[stray]  = 16'($urandom);
      end
      @(negedge clk_i);
      hdr_valid_i = 1'b0;
      in_valid_i  = '0;
      check_value("unexpected_o", 32'(unexpected_o), (stray < NumRoutes) ? 1 : 0);
      check_value("mcast_valid_o", 32'(mcast_valid_o), 0);
      // Expected directions in random order
      while (order.size() != 0) begin
        pick                   = $urandom % order.size();
        data                   = 16'($urandom);
        in_valid_i[order[pick]] = 1'b1;
        in_data_i[order[pick]]  = data;
        exp_sum                = exp_sum + data;
        order.delete(pick);
        @(negedge clk_i);
        in_valid_i = '0;
        check_value("unexpected_o", 32'(unexpected_o), 0);
        if (order.size() != 0) begin
          check_value("red_valid_o", 32'(red_valid_o), 0);
          check_value("busy_o", 32'(busy_o), 1);
        end
      end
      wait_cycles = 0;
      while (red_valid_o !== 1'b1) begin
        if (wait_cycles >= Timeout) begin
          abort_run("Timed out waiting for red_valid_o after the last arrival");
        end
        @(negedge clk_i);
        wait_cycles++;
      end
    end
    check_value("red_valid_o", 32'(red_valid_o), 1);
    check_value("red_data_o", 32'(red_data_o), 32'(exp_sum));
    check_value("red_route_o", 32'(red_route_o),
                32'(xy_hop(c[38:36], c[34:32], c[22:20], c[18:16])));
    check_value("busy_o", 32'(busy_o), 0);
    check_value("mcast_valid_o", 32'(mcast_valid_o), 0);
    @(negedge clk_i);
    check_value("red_valid_o", 32'(red_valid_o), 0);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    void'($urandom(55));
    rst_i       = 1'b1;
    xy_id_i     = '0;
    hdr_valid_i = 1'b0;
    hdr_i       = '0;
    in_valid_i  = '0;
    in_data_i   = '0;
    for (int unsigned i = 0; i < MaxCases; i++) begin
      cases_mem[i] = {4'hf, 40'(i)};
    end
    $readmemh("tests/coll_cases.txt", cases_mem);
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    // Quiet outputs until the first header
    repeat (3) begin
      @(negedge clk_i);
      check_value("mcast_valid_o", 32'(mcast_valid_o), 0);
      check_value("red_valid_o", 32'(red_valid_o), 0);
      check_value("busy_o", 32'(busy_o), 0);
      check_value("unexpected_o", 32'(unexpected_o), 0);
    end
    num_cases = 0;
    while ((num_cases < MaxCases) && (cases_mem[num_cases][43:40] != 4'hf)) begin
      case (cases_mem[num_cases][43:40])
        4'h0:    run_mcast(cases_mem[num_cases]);
        4'h1:    run_reduction(cases_mem[num_cases]);
        default: abort_run("Case file holds an unknown mode");
      endcase
      num_cases++;
    end
    if (num_cases == 0) begin
      abort_run("No cases were read from the case file");
    end else begin
      $display("Ran %0d cases", num_cases);
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule
